//--- hdl/rp_pkg.sv
// shared widths, bus address map, register offsets and sample type; reference by rp_pkg::name
package rp_pkg;

  ////////////////////////////////////////////////////////////
  // system bus
  ////////////////////////////////////////////////////////////
  localparam int BUS_W      = 32;  // data and address
  localparam int REGION_LSB = 20;  // region index starts here
  localparam int REGION_W   = 3;   // addr[22:20]
  localparam int REGION_NUM = 8;

  // mapped regions, the rest answer with zero
  localparam logic [REGION_W-1:0] REGION_HK     = 3'd0;
  localparam logic [REGION_W-1:0] REGION_ANALOG = 3'd1;
  localparam logic [REGION_W-1:0] REGION_PWM    = 3'd4;  // slow dac config

  ////////////////////////////////////////////////////////////
  // register offsets inside a region
  ////////////////////////////////////////////////////////////
  localparam logic [REGION_LSB-1:0] OFS_ID    = 20'h00;  // housekeeping
  localparam logic [REGION_LSB-1:0] OFS_LOOP  = 20'h04;
  localparam logic [REGION_LSB-1:0] OFS_LED   = 20'h08;
  localparam logic [REGION_LSB-1:0] OFS_ADC_A = 20'h00;  // analog
  localparam logic [REGION_LSB-1:0] OFS_ADC_B = 20'h04;
  localparam logic [REGION_LSB-1:0] OFS_DAC_A = 20'h08;
  localparam logic [REGION_LSB-1:0] OFS_DAC_B = 20'h0C;
  localparam logic [REGION_LSB-1:0] OFS_PWM0  = 20'h00;  // slow dac
  localparam logic [REGION_LSB-1:0] OFS_PWM1  = 20'h04;
  localparam logic [REGION_LSB-1:0] OFS_PWM2  = 20'h08;
  localparam logic [REGION_LSB-1:0] OFS_PWM3  = 20'h0C;

  localparam logic [BUS_W-1:0] HK_ID = 32'h5250_0001;  // board id word

  // samples and leds
  localparam int ADC_PIN_W = 16;  // bits 1..0 left for a 16 bit part
  localparam int SAMPLE_W  = 14;
  localparam int LED_W     = 8;

  // pwm bank
  localparam int PWM_NUM    = 4;
  localparam int PWM_CFG_W  = 24;   // level in [23:16], dither in [15:0]
  localparam int PWM_PERIOD = 156;  // cycles per period
  localparam int PWM_SEQ    = 16;   // periods per dither sequence

  // one sample word, seen as a number or as sign plus body
  typedef union packed {
    logic [SAMPLE_W-1:0] raw;
    struct packed {
      logic                msb;
      logic [SAMPLE_W-2:0] body;
    } fld;
  } sample_u;

endpackage

//--- hdl/sys_bus_decode.sv
// system bus decoder; splits the address space into eight regions and merges the slave answers
`timescale 1ns/1ps

module sys_bus_decode
(
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::BUS_W-1:0] sys_addr_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  input  logic [rp_pkg::BUS_W-1:0] hk_rdata_i,
  input  logic                     hk_ack_i,
  input  logic [rp_pkg::BUS_W-1:0] ana_rdata_i,
  input  logic                     ana_ack_i,
  input  logic [rp_pkg::BUS_W-1:0] pwm_rdata_i,
  input  logic                     pwm_ack_i,
  output logic                     hk_wen_o,
  output logic                     hk_ren_o,
  output logic                     ana_wen_o,
  output logic                     ana_ren_o,
  output logic                     pwm_wen_o,
  output logic                     pwm_ren_o,
  output logic [rp_pkg::BUS_W-1:0] sys_rdata_o,
  output logic                     sys_ack_o
);

  logic [rp_pkg::REGION_W-1:0]   region;     // region of the current strobe
  logic [rp_pkg::REGION_NUM-1:0] region_oh;
  logic                          mapped;     // one of the three slaves
  logic [rp_pkg::REGION_W-1:0]   region_q;   // region of the access in flight
  logic                          unm_ack_q;  // own ack for empty regions

  assign region    = sys_addr_i[rp_pkg::REGION_LSB +: rp_pkg::REGION_W];
  assign region_oh = {{(rp_pkg::REGION_NUM-1){1'b0}}, 1'b1} << region;
  assign mapped    = region_oh[rp_pkg::REGION_HK] | region_oh[rp_pkg::REGION_ANALOG]
                   | region_oh[rp_pkg::REGION_PWM];

  // per slave strobes
  assign hk_wen_o  = sys_wen_i & region_oh[rp_pkg::REGION_HK];
  assign hk_ren_o  = sys_ren_i & region_oh[rp_pkg::REGION_HK];
  assign ana_wen_o = sys_wen_i & region_oh[rp_pkg::REGION_ANALOG];
  assign ana_ren_o = sys_ren_i & region_oh[rp_pkg::REGION_ANALOG];
  assign pwm_wen_o = sys_wen_i & region_oh[rp_pkg::REGION_PWM];
  assign pwm_ren_o = sys_ren_i & region_oh[rp_pkg::REGION_PWM];

  ////////////////////////////////////////////////////////////
  // region tracking
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      region_q  <= '0;
      unm_ack_q <= 1'b0;
    end
    else
    begin
      if (sys_wen_i || sys_ren_i)
        region_q <= region;                                  // hold for the answer cycle
      unm_ack_q <= (sys_wen_i || sys_ren_i) && !mapped;  // empty region acks itself
    end
  end

  // answer merge, select comes from the registered region
  always_comb
  begin
    case (region_q)
      rp_pkg::REGION_HK:     begin sys_rdata_o = hk_rdata_i;  sys_ack_o = hk_ack_i;  end
      rp_pkg::REGION_ANALOG: begin sys_rdata_o = ana_rdata_i; sys_ack_o = ana_ack_i; end
      rp_pkg::REGION_PWM:    begin sys_rdata_o = pwm_rdata_i; sys_ack_o = pwm_ack_i; end
      default:               begin sys_rdata_o = '0;          sys_ack_o = unm_ack_q; end
    endcase
  end

endmodule

//--- hdl/hk_regs.sv
// housekeeping slave in region 0; holds the id word, the led register and the digital loop bit
`timescale 1ns/1ps

module hk_regs
(
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::BUS_W-1:0] sys_addr_i,
  input  logic [rp_pkg::BUS_W-1:0] sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [rp_pkg::BUS_W-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic [rp_pkg::LED_W-1:0] led_o,
  output logic                     digital_loop_o
);

  logic [rp_pkg::REGION_LSB-1:0] offset;

  assign offset = sys_addr_i[rp_pkg::REGION_LSB-1:0];  // offset inside region

  ////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      led_o          <= '0;
      digital_loop_o <= 1'b0;  // loop off out of reset
      sys_ack_o      <= 1'b0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;  // every strobe answered
      if (sys_wen_i)
      begin
        case (offset)
          rp_pkg::OFS_LOOP: digital_loop_o <= sys_wdata_i[0];
          rp_pkg::OFS_LED:  led_o          <= sys_wdata_i[rp_pkg::LED_W-1:0];
          default:          ;  // id is read only
        endcase
      end
    end
  end

  // read data, zero after a write or at an unknown offset
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (offset)
        rp_pkg::OFS_ID:   sys_rdata_o <= rp_pkg::HK_ID;
        rp_pkg::OFS_LOOP: sys_rdata_o <= {{(rp_pkg::BUS_W-1){1'b0}}, digital_loop_o};
        rp_pkg::OFS_LED:  sys_rdata_o <= {{(rp_pkg::BUS_W-rp_pkg::LED_W){1'b0}}, led_o};
        default:          sys_rdata_o <= '0;
      endcase
    end
    else
      sys_rdata_o <= '0;
  end

endmodule

//--- hdl/analog_io.sv
// analog slave in region 1; adc capture and conversion, dac code registers and pin drive
`timescale 1ns/1ps

module analog_io
(
  input  logic                             adc_clk,
  input  logic                             rst_n_i,
  input  logic [rp_pkg::BUS_W-1:0]         sys_addr_i,
  input  logic [rp_pkg::BUS_W-1:0]         sys_wdata_i,
  input  logic                             sys_wen_i,
  input  logic                             sys_ren_i,
  input  logic                             digital_loop_i,
  input  logic [rp_pkg::ADC_PIN_W-1:0]     adc_dat_a_i,
  input  logic [rp_pkg::ADC_PIN_W-1:0]     adc_dat_b_i,
  output logic [rp_pkg::BUS_W-1:0]         sys_rdata_o,
  output logic                             sys_ack_o,
  output logic [rp_pkg::SAMPLE_W-1:0]      dac_dat_a_o,
  output logic [rp_pkg::SAMPLE_W-1:0]      dac_dat_b_o
);

  logic [rp_pkg::REGION_LSB-1:0] offset;
  rp_pkg::sample_u               adc_a_q;    // raw pin samples
  rp_pkg::sample_u               adc_b_q;
  rp_pkg::sample_u               adc_a;      // two's complement, or loop data
  rp_pkg::sample_u               adc_b;
  rp_pkg::sample_u               dac_a_q;    // dac codes, two's complement
  rp_pkg::sample_u               dac_b_q;
  rp_pkg::sample_u               dac_pin_a;  // codes in pin format
  rp_pkg::sample_u               dac_pin_b;

  // negative slope <-> two's complement, same rule both ways
  function automatic rp_pkg::sample_u flip_slope(input rp_pkg::sample_u s);
    rp_pkg::sample_u f;
    f.fld.msb  = s.fld.msb;    // sign position stays
    f.fld.body = ~s.fld.body;  // magnitude runs the other way
    return f;
  endfunction

  // sign extend to bus width
  function automatic logic [rp_pkg::BUS_W-1:0] sext(input rp_pkg::sample_u s);
    return {{(rp_pkg::BUS_W-rp_pkg::SAMPLE_W){s.fld.msb}}, s.raw};
  endfunction

  assign offset = sys_addr_i[rp_pkg::REGION_LSB-1:0];

  ////////////////////////////////////////////////////////////
  // adc side
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    adc_a_q.raw <= adc_dat_a_i[rp_pkg::ADC_PIN_W-1 -: rp_pkg::SAMPLE_W];  // drop 2 lsbs
    adc_b_q.raw <= adc_dat_b_i[rp_pkg::ADC_PIN_W-1 -: rp_pkg::SAMPLE_W];
  end

  assign adc_a = digital_loop_i ? dac_a_q : flip_slope(adc_a_q);  // loop feeds dac back
  assign adc_b = digital_loop_i ? dac_b_q : flip_slope(adc_b_q);

  ////////////////////////////////////////////////////////////
  // dac side
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_a_q   <= '0;  // zero code
      dac_b_q   <= '0;
      sys_ack_o <= 1'b0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      if (sys_wen_i && offset == rp_pkg::OFS_DAC_A)
        dac_a_q.raw <= sys_wdata_i[rp_pkg::SAMPLE_W-1:0];
      if (sys_wen_i && offset == rp_pkg::OFS_DAC_B)
        dac_b_q.raw <= sys_wdata_i[rp_pkg::SAMPLE_W-1:0];
    end
  end

  assign dac_pin_a = flip_slope(dac_a_q);
  assign dac_pin_b = flip_slope(dac_b_q);

  // pin register, one edge after the code register
  always_ff @(posedge adc_clk)
  begin
    dac_dat_a_o <= dac_pin_a.raw;
    dac_dat_b_o <= dac_pin_b.raw;
  end

  // read return
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (offset)
        rp_pkg::OFS_ADC_A: sys_rdata_o <= sext(adc_a);
        rp_pkg::OFS_ADC_B: sys_rdata_o <= sext(adc_b);
        rp_pkg::OFS_DAC_A: sys_rdata_o <= sext(dac_a_q);
        rp_pkg::OFS_DAC_B: sys_rdata_o <= sext(dac_b_q);
        default:           sys_rdata_o <= '0;
      endcase
    end
    else
      sys_rdata_o <= '0;  // writes answer zero
  end

endmodule

//--- hdl/pwm_bank.sv
// slow dac slave in region 4; four config words driving four dithered pwm outputs
`timescale 1ns/1ps

module pwm_bank
(
  input  logic                       adc_clk,
  input  logic                       rst_n_i,
  input  logic [rp_pkg::BUS_W-1:0]   sys_addr_i,
  input  logic [rp_pkg::BUS_W-1:0]   sys_wdata_i,
  input  logic                       sys_wen_i,
  input  logic                       sys_ren_i,
  output logic [rp_pkg::BUS_W-1:0]   sys_rdata_o,
  output logic                       sys_ack_o,
  output logic [rp_pkg::PWM_NUM-1:0] pwm_o
);

  logic [rp_pkg::REGION_LSB-1:0]             offset;
  logic [rp_pkg::PWM_CFG_W-1:0]              cfg_q  [rp_pkg::PWM_NUM];  // bus side
  logic [rp_pkg::PWM_CFG_W-1:0]              work_q [rp_pkg::PWM_NUM];  // used this sequence
  logic [rp_pkg::PWM_CFG_W-rp_pkg::PWM_SEQ:0] high_len [rp_pkg::PWM_NUM];
  logic [$clog2(rp_pkg::PWM_PERIOD)-1:0]     per_cnt;
  logic [$clog2(rp_pkg::PWM_SEQ)-1:0]        seq_cnt;
  logic                                      per_last;
  logic                                      seq_wrap;

  assign offset = sys_addr_i[rp_pkg::REGION_LSB-1:0];

  ////////////////////////////////////////////////////////////
  // bus registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      cfg_q     <= '{default: '0};
      sys_ack_o <= 1'b0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      if (sys_wen_i)
      begin
        case (offset)
          rp_pkg::OFS_PWM0: cfg_q[0] <= sys_wdata_i[rp_pkg::PWM_CFG_W-1:0];
          rp_pkg::OFS_PWM1: cfg_q[1] <= sys_wdata_i[rp_pkg::PWM_CFG_W-1:0];
          rp_pkg::OFS_PWM2: cfg_q[2] <= sys_wdata_i[rp_pkg::PWM_CFG_W-1:0];
          rp_pkg::OFS_PWM3: cfg_q[3] <= sys_wdata_i[rp_pkg::PWM_CFG_W-1:0];
          default:          ;
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (offset)
        rp_pkg::OFS_PWM0: sys_rdata_o <= {{(rp_pkg::BUS_W-rp_pkg::PWM_CFG_W){1'b0}}, cfg_q[0]};
        rp_pkg::OFS_PWM1: sys_rdata_o <= {{(rp_pkg::BUS_W-rp_pkg::PWM_CFG_W){1'b0}}, cfg_q[1]};
        rp_pkg::OFS_PWM2: sys_rdata_o <= {{(rp_pkg::BUS_W-rp_pkg::PWM_CFG_W){1'b0}}, cfg_q[2]};
        rp_pkg::OFS_PWM3: sys_rdata_o <= {{(rp_pkg::BUS_W-rp_pkg::PWM_CFG_W){1'b0}}, cfg_q[3]};
        default:          sys_rdata_o <= '0;
      endcase
    end
    else
      sys_rdata_o <= '0;
  end

  ////////////////////////////////////////////////////////////
  // shared period and sequence counters
  ////////////////////////////////////////////////////////////
  assign per_last = (per_cnt == rp_pkg::PWM_PERIOD-1);
  assign seq_wrap = per_last && (seq_cnt == rp_pkg::PWM_SEQ-1);  // last cycle of sequence

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      per_cnt <= '0;
      seq_cnt <= '0;
      work_q  <= '{default: '0};  // level 0, no dither, outputs stay low
    end
    else
    begin
      per_cnt <= per_last ? '0 : per_cnt + 1'b1;
      if (per_last)
        seq_cnt <= seq_wrap ? '0 : seq_cnt + 1'b1;
      if (seq_wrap)
        work_q <= cfg_q;  // new config from next sequence on
    end
  end

  // high time in this period = level + dither bit of period index
  always_comb
  begin
    for (int n = 0; n < rp_pkg::PWM_NUM; n++)
      high_len[n] = {1'b0, work_q[n][rp_pkg::PWM_CFG_W-1:rp_pkg::PWM_SEQ]}
                  + work_q[n][seq_cnt];
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      pwm_o <= '0;
    else
      for (int n = 0; n < rp_pkg::PWM_NUM; n++)
        pwm_o[n] <= (per_cnt < high_len[n]);
  end

endmodule

//--- hdl/rp_top.sv
// top level of the analog front end; bus decoder, three slaves and the board pins in one domain
`timescale 1ns/1ps

module rp_top
(
  input  logic                         adc_clk,
  input  logic                         rst_n_i,
  // system bus
  input  logic [rp_pkg::BUS_W-1:0]     sys_addr_i,
  input  logic [rp_pkg::BUS_W-1:0]     sys_wdata_i,
  input  logic                         sys_wen_i,
  input  logic                         sys_ren_i,
  output logic [rp_pkg::BUS_W-1:0]     sys_rdata_o,
  output logic                         sys_ack_o,
  // adc and dac pins
  input  logic [rp_pkg::ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [rp_pkg::ADC_PIN_W-1:0] adc_dat_b_i,
  output logic [rp_pkg::SAMPLE_W-1:0]  dac_dat_a_o,
  output logic [rp_pkg::SAMPLE_W-1:0]  dac_dat_b_o,
  // board io
  output logic [rp_pkg::LED_W-1:0]     led_o,
  output logic [rp_pkg::PWM_NUM-1:0]   pwm_o      // slow dac pwm
);

  ////////////////////////////////////////////////////////////
  // per slave bus wires
  ////////////////////////////////////////////////////////////
  logic                     hk_wen,  hk_ren,  hk_ack;
  logic                     ana_wen, ana_ren, ana_ack;
  logic                     pwm_wen, pwm_ren, pwm_ack;
  logic [rp_pkg::BUS_W-1:0] hk_rdata;
  logic [rp_pkg::BUS_W-1:0] ana_rdata;
  logic [rp_pkg::BUS_W-1:0] pwm_rdata;
  logic                     digital_loop;  // hk -> analog

  sys_bus_decode u_decode
  (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .ana_rdata_i (ana_rdata),
    .ana_ack_i   (ana_ack),
    .pwm_rdata_i (pwm_rdata),
    .pwm_ack_i   (pwm_ack),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .ana_wen_o   (ana_wen),
    .ana_ren_o   (ana_ren),
    .pwm_wen_o   (pwm_wen),
    .pwm_ren_o   (pwm_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o)
  );

  hk_regs u_hk
  (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (hk_wen),
    .sys_ren_i      (hk_ren),
    .sys_rdata_o    (hk_rdata),
    .sys_ack_o      (hk_ack),
    .led_o          (led_o),
    .digital_loop_o (digital_loop)
  );

  analog_io u_analog
  (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (ana_wen),
    .sys_ren_i      (ana_ren),
    .digital_loop_i (digital_loop),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .sys_rdata_o    (ana_rdata),
    .sys_ack_o      (ana_ack),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

  pwm_bank u_pwm
  (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (pwm_wen),
    .sys_ren_i   (pwm_ren),
    .sys_rdata_o (pwm_rdata),
    .sys_ack_o   (pwm_ack),
    .pwm_o       (pwm_o)
  );

endmodule

//--- verification/rp_top_assertions.sv
// concurrent bus handshake and reset checks, bound into rp_top from this file
`timescale 1ns/1ps

module rp_top_assertions
(
  input logic                       adc_clk,
  input logic                       rst_n_i,
  input logic                       sys_wen_i,
  input logic                       sys_ren_i,
  input logic                       sys_ack_o,
  input logic [rp_pkg::LED_W-1:0]   led_o,
  input logic [rp_pkg::PWM_NUM-1:0] pwm_o
);

  int fail_cnt = 0;  // failure tally for the end of run summary

  // every strobe answered on the very next edge
  a_ack_follows: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o)
    else
    begin
      $error("strobe without an ack on the next edge");
      fail_cnt++;
    end

  // ack only ever answers a strobe one cycle back
  a_no_stray_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i))
    else
    begin
      $error("ack seen with no strobe in the cycle before");
      fail_cnt++;
    end

  // outputs quiet in reset, one edge in for the sync reset to land
  a_reset_quiet: assert property (@(posedge adc_clk)
    (!rst_n_i && $past(!rst_n_i)) |-> (led_o == '0 && pwm_o == '0))
    else
    begin
      $error("led or pwm outputs active during reset");
      fail_cnt++;
    end

endmodule

bind rp_top rp_top_assertions u_assertions
(
  .adc_clk   (adc_clk),
  .rst_n_i   (rst_n_i),
  .sys_wen_i (sys_wen_i),
  .sys_ren_i (sys_ren_i),
  .sys_ack_o (sys_ack_o),
  .led_o     (led_o),
  .pwm_o     (pwm_o)
);

//--- verification/rp_top_tb.sv
// table driven testbench for rp_top; run with the src.f file list, top module rp_top_tb
`timescale 1ns/1ps

module rp_top_tb;

  localparam int MAX_TESTS = 64;
  localparam int ACK_WAIT  = 8;  // cycles before a missing ack is reported
  localparam int SEQ_LEN   = rp_pkg::PWM_SEQ * rp_pkg::PWM_PERIOD;  // one dither sequence
  localparam bit WR        = 1'b1;
  localparam bit RD        = 1'b0;
  localparam int PIN_NONE  = 0;  // side effect to look at after the access
  localparam int PIN_LED   = 1;
  localparam int PIN_DAC_A = 2;
  localparam int PIN_DAC_B = 3;

  logic                         adc_clk = 1'b0;
  logic                         rst_n_i;
  logic [rp_pkg::BUS_W-1:0]     sys_addr_i;
  logic [rp_pkg::BUS_W-1:0]     sys_wdata_i;
  logic                         sys_wen_i;
  logic                         sys_ren_i;
  logic [rp_pkg::BUS_W-1:0]     sys_rdata_o;
  logic                         sys_ack_o;
  logic [rp_pkg::ADC_PIN_W-1:0] adc_dat_a_i;
  logic [rp_pkg::ADC_PIN_W-1:0] adc_dat_b_i;
  logic [rp_pkg::SAMPLE_W-1:0]  dac_dat_a_o;
  logic [rp_pkg::SAMPLE_W-1:0]  dac_dat_b_o;
  logic [rp_pkg::LED_W-1:0]     led_o;
  logic [rp_pkg::PWM_NUM-1:0]   pwm_o;

  ////////////////////////////////////////////////////////////
  // test table, one row per bus access
  ////////////////////////////////////////////////////////////
  string       t_name   [MAX_TESTS];
  bit          t_wr     [MAX_TESTS];
  logic [2:0]  t_region [MAX_TESTS];
  logic [19:0] t_ofs    [MAX_TESTS];
  logic [31:0] t_data   [MAX_TESTS];
  logic [31:0] t_exp    [MAX_TESTS];  // expected rdata, zero for writes
  logic [31:0] t_adc    [MAX_TESTS];  // {pin a, pin b} held during the access
  int          t_pin    [MAX_TESTS];
  logic [31:0] t_pin_exp[MAX_TESTS];

  logic [rp_pkg::PWM_CFG_W-1:0] pwm_cfg [rp_pkg::PWM_NUM];
  int          n_tests;
  int          tests_run;
  int          errors;
  integer      seed = 32'h4ae2_8bab;
  logic [31:0] next_adc;  // pins for rows added next

  always #50 adc_clk = ~adc_clk;  // 100 ns period

  rp_top u_dut
  (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .led_o       (led_o),
    .pwm_o       (pwm_o)
  );

  // adc pins -> readback: top 14 bits, msb kept, body inverted, sign extended
  function automatic logic [31:0] adc_expect(input logic [15:0] pins);
    rp_pkg::sample_u s;
    s.raw      = pins[15:2];
    s.fld.body = ~s.fld.body;
    return {{(rp_pkg::BUS_W-rp_pkg::SAMPLE_W){s.fld.msb}}, s.raw};
  endfunction

  // dac code -> pin word, same sign keep body invert rule
  function automatic logic [31:0] dac_pin_expect(input logic [13:0] code);
    rp_pkg::sample_u s;
    s.raw      = code;
    s.fld.body = ~s.fld.body;
    return {18'd0, s.raw};
  endfunction

  function automatic logic [31:0] code_expect(input logic [13:0] code);
    return {{18{code[13]}}, code};  // codes read back sign extended
  endfunction

  // high cycles per sequence, level every period plus one per dither bit
  function automatic int pwm_expect(input logic [rp_pkg::PWM_CFG_W-1:0] cfg);
    int cnt;
    cnt = rp_pkg::PWM_SEQ * int'(cfg[23:16]);
    for (int k = 0; k < rp_pkg::PWM_SEQ; k++)
      cnt += cfg[k];
    return cnt;
  endfunction

  task automatic check(input string name, input logic [31:0] expv, input logic [31:0] actv);
    if (actv !== expv)
    begin
      $display("Fail %s: expected %h, actual %h", name, expv, actv);
      errors++;
    end
  endtask

  task automatic add_test(input string name, input bit wr, input logic [2:0] region,
                          input logic [19:0] ofs, input logic [31:0] data,
                          input logic [31:0] expv, input int pin_sel,
                          input logic [31:0] pin_exp);
    t_name[n_tests]    = name;
    t_wr[n_tests]      = wr;
    t_region[n_tests]  = region;
    t_ofs[n_tests]     = ofs;
    t_data[n_tests]    = data;
    t_exp[n_tests]     = expv;
    t_adc[n_tests]     = next_adc;
    t_pin[n_tests]     = pin_sel;
    t_pin_exp[n_tests] = pin_exp;
    n_tests++;
  endtask

  task automatic build_table();
    logic [13:0] code_a;
    logic [13:0] code_b;
    code_a   = 14'h2A5C;  // negative
    code_b   = 14'h0123;  // positive
    n_tests  = 0;
    next_adc = '0;
    // housekeeping
    add_test("hk_id", RD, rp_pkg::REGION_HK, rp_pkg::OFS_ID, 0, rp_pkg::HK_ID, PIN_NONE, 0);
    add_test("led_write", WR, rp_pkg::REGION_HK, rp_pkg::OFS_LED, 32'hA5, 0, PIN_LED, 32'hA5);
    add_test("led_read", RD, rp_pkg::REGION_HK, rp_pkg::OFS_LED, 0, 32'hA5, PIN_NONE, 0);
    add_test("hk_unknown", RD, rp_pkg::REGION_HK, 20'h10, 0, 0, PIN_NONE, 0);
    add_test("loop_off_read", RD, rp_pkg::REGION_HK, rp_pkg::OFS_LOOP, 0, 0, PIN_NONE, 0);
    // random adc pins
    for (int k = 0; k < 3; k++)
    begin
      next_adc = $random(seed);
      add_test("adc_a_rand", RD, rp_pkg::REGION_ANALOG, rp_pkg::OFS_ADC_A, 0,
               adc_expect(next_adc[31:16]), PIN_NONE, 0);
      add_test("adc_b_rand", RD, rp_pkg::REGION_ANALOG, rp_pkg::OFS_ADC_B, 0,
               adc_expect(next_adc[15:0]), PIN_NONE, 0);
    end
    // dac codes and digital loop
    add_test("dac_a_write", WR, rp_pkg::REGION_ANALOG, rp_pkg::OFS_DAC_A, 32'(code_a), 0,
             PIN_DAC_A, dac_pin_expect(code_a));
    add_test("dac_b_write", WR, rp_pkg::REGION_ANALOG, rp_pkg::OFS_DAC_B, 32'(code_b), 0,
             PIN_DAC_B, dac_pin_expect(code_b));
    add_test("dac_a_read", RD, rp_pkg::REGION_ANALOG, rp_pkg::OFS_DAC_A, 0,
             code_expect(code_a), PIN_NONE, 0);
    add_test("loop_on", WR, rp_pkg::REGION_HK, rp_pkg::OFS_LOOP, 1, 0, PIN_NONE, 0);
    add_test("loop_on_read", RD, rp_pkg::REGION_HK, rp_pkg::OFS_LOOP, 0, 1, PIN_NONE, 0);
    next_adc = $random(seed);  // pins must not leak through
    add_test("loop_adc_a", RD, rp_pkg::REGION_ANALOG, rp_pkg::OFS_ADC_A, 0,
             code_expect(code_a), PIN_NONE, 0);
    add_test("loop_adc_b", RD, rp_pkg::REGION_ANALOG, rp_pkg::OFS_ADC_B, 0,
             code_expect(code_b), PIN_NONE, 0);
    add_test("loop_clear", WR, rp_pkg::REGION_HK, rp_pkg::OFS_LOOP, 0, 0, PIN_NONE, 0);
    add_test("pins_adc_a", RD, rp_pkg::REGION_ANALOG, rp_pkg::OFS_ADC_A, 0,
             adc_expect(next_adc[31:16]), PIN_NONE, 0);
    add_test("pins_adc_b", RD, rp_pkg::REGION_ANALOG, rp_pkg::OFS_ADC_B, 0,
             adc_expect(next_adc[15:0]), PIN_NONE, 0);
    // empty regions, both directions
    for (int r = 0; r < rp_pkg::REGION_NUM; r++)
    begin
      if (r != rp_pkg::REGION_HK && r != rp_pkg::REGION_ANALOG && r != rp_pkg::REGION_PWM)
      begin
        add_test($sformatf("unm%0d_wr", r), WR, 3'(r), 20'h0, 32'hDEAD_BEEF, 0, PIN_NONE, 0);
        add_test($sformatf("unm%0d_rd", r), RD, 3'(r), 20'h0, 0, 0, PIN_NONE, 0);
      end
    end
    // slow dac config, written then read back
    pwm_cfg[0] = 24'h0A_0000;  // flat level
    pwm_cfg[1] = 24'h4D_A5A5;
    pwm_cfg[2] = 24'h00_0001;  // single dither pulse
    pwm_cfg[3] = 24'h9B_FFFF;  // top level, full period every time
    for (int n = 0; n < rp_pkg::PWM_NUM; n++)
      add_test($sformatf("pwm%0d_write", n), WR, rp_pkg::REGION_PWM, 20'(n * 4),
               32'(pwm_cfg[n]), 0, PIN_NONE, 0);
    for (int n = 0; n < rp_pkg::PWM_NUM; n++)
      add_test($sformatf("pwm%0d_read", n), RD, rp_pkg::REGION_PWM, 20'(n * 4), 0,
               {8'd0, pwm_cfg[n]}, PIN_NONE, 0);
  endtask

  // one strobe, then wait for the ack, called 1 ns after an edge
  task automatic bus_access(input bit wr, input logic [31:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output bit acked);
    int waits;
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    @(posedge adc_clk);
    #1;
    sys_wen_i = 1'b0;  // single cycle strobe
    sys_ren_i = 1'b0;
    waits     = 0;
    while (!sys_ack_o && waits < ACK_WAIT)
    begin
      @(posedge adc_clk);
      #1;
      waits++;
    end
    acked = sys_ack_o;
    rdata = sys_rdata_o;
  endtask

  task automatic run_entry(input int i);
    logic [31:0] rdata;
    logic [31:0] pin_val;
    bit          acked;
    int          errs_before;
    errs_before = errors;
    adc_dat_a_i = t_adc[i][31:16];
    adc_dat_b_i = t_adc[i][15:0];
    @(posedge adc_clk);  // pins captured before the strobe
    #1;
    bus_access(t_wr[i], {9'd0, t_region[i], t_ofs[i]}, t_data[i], rdata, acked);
    if (!acked)
    begin
      $display("no acknowledge for test %s within %0d cycles", t_name[i], ACK_WAIT);
      errors++;
    end
    else
      check(t_name[i], t_exp[i], rdata);
    if (t_pin[i] != PIN_NONE)
    begin
      // led lands with the ack, dac pins lag the code register by one edge
      if (t_pin[i] != PIN_LED)
      begin
        @(posedge adc_clk);
        #1;
      end
      case (t_pin[i])
        PIN_LED:   pin_val = {24'd0, led_o};
        PIN_DAC_A: pin_val = {18'd0, dac_dat_a_o};
        default:   pin_val = {18'd0, dac_dat_b_o};
      endcase
      check({t_name[i], "_pin"}, t_pin_exp[i], pin_val);
    end
    tests_run++;
    $display("test %0d %s: %s", i, t_name[i], (errors == errs_before) ? "ok" : "mismatch");
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    int hi_cnt [rp_pkg::PWM_NUM];
    int errs_before;
    rst_n_i     = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    errors      = 0;
    tests_run   = 0;
    build_table();
    repeat (16) @(posedge adc_clk);
    #1;
    rst_n_i = 1'b1;
    // state straight out of reset
    errs_before = errors;
    check("reset_led", 0, led_o);
    check("reset_pwm", 0, pwm_o);
    check("reset_ack", 0, sys_ack_o);
    check("reset_dac_a", dac_pin_expect(14'd0), dac_dat_a_o);
    check("reset_dac_b", dac_pin_expect(14'd0), dac_dat_b_o);
    tests_run++;
    $display("test reset_state: %s", (errors == errs_before) ? "ok" : "mismatch");
    for (int i = 0; i < n_tests; i++)
      run_entry(i);
    // new config lands at a sequence start, then count one whole sequence
    errs_before = errors;
    repeat (SEQ_LEN + 4) @(posedge adc_clk);
    #1;
    for (int n = 0; n < rp_pkg::PWM_NUM; n++)
      hi_cnt[n] = 0;
    repeat (SEQ_LEN)
    begin
      for (int n = 0; n < rp_pkg::PWM_NUM; n++)
        hi_cnt[n] += pwm_o[n];
      @(posedge adc_clk);
      #1;
    end
    for (int n = 0; n < rp_pkg::PWM_NUM; n++)
      check($sformatf("pwm%0d_count", n), pwm_expect(pwm_cfg[n]), hi_cnt[n]);
    tests_run++;
    $display("test pwm_count: %s", (errors == errs_before) ? "ok" : "mismatch");
    // bound handshake and reset checks
    if (u_dut.u_assertions.fail_cnt != 0)
    begin
      $display("%0d concurrent assertion failures during the run",
               u_dut.u_assertions.fail_cnt);
      errors += u_dut.u_assertions.fail_cnt;
    end
    $display("tests run: %0d, checks failed: %0d", tests_run, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // watchdog, sized from the table plus two dither sequences
  initial
  begin
    int limit;
    #1;  // table is built at time zero
    limit = 16 + n_tests * 20 + 2 * SEQ_LEN;
    repeat (limit) @(posedge adc_clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- src.f
hdl/rp_pkg.sv
hdl/sys_bus_decode.sv
hdl/hk_regs.sv
hdl/analog_io.sv
hdl/pwm_bank.sv
hdl/rp_top.sv
verification/rp_top_assertions.sv
verification/rp_top_tb.sv
